// ==== tb.f ====
logic/aluIsaPkg.sv
logic/aluDataPkg.sv
logic/aluCompare.sv
logic/aluCountLead.sv
logic/aluShifter.sv
logic/aluCore.sv
logic/aluExecStage.sv
dv/aluExec_assert.sv
dv/aluTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the execute-stage testbench with Verilator and runs it.
# Exits non-zero unless the simulation output reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module aluTb -o aluSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/aluSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
exit 1

// ==== dv/aluTb.sv ====
/* Directed tests of aluExecStage at its default width. Inputs change 1 ns after
   the rising edge and outputs are sampled at that same point */
`timescale 1ns/100ps
`default_nettype none

module aluTb;

	localparam int width = aluDataPkg::defaultValueWidth;
	localparam int irW = aluIsaPkg::instrWidth;
	localparam int halfPeriod = 4;
	// Issues per test: arith 40, logic 28, compare 36, shift 32, back-to-back 18
	localparam int issueTotal = 40 + 28 + 36 + 32 + 18;
	// Four cycles per issue plus room for reset and the idle checks
	localparam int watchdogCycles = issueTotal * 4 + 60;

	logic clk;
	logic rstN;
	logic issue;
	logic [irW-1:0] ir;
	logic [width-1:0] xa;
	logic [width-1:0] xb;
	logic [width-1:0] xc;
	logic [width-1:0] imm;
	logic carryIn;
	logic done;
	logic [width-1:0] result;
	logic [width-1:0] carryRes;

	int checks = 0;
	int errors = 0;

	aluExecStage uut (
		.clk(clk),
		.rstN(rstN),
		.issue(issue),
		.ir(ir),
		.xa(xa),
		.xb(xb),
		.xc(xc),
		.imm(imm),
		.carryIn(carryIn),
		.done(done),
		.result(result),
		.carryRes(carryRes)
	);

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Ends a run that stalls anywhere
	initial
	begin
		#(watchdogCycles * 2 * halfPeriod);
		$display("Timeout: tests still running after %0d clock cycles", watchdogCycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic logic [irW-1:0] makeIr(
		input logic [aluIsaPkg::opcodeWidth-1:0] op,
		input logic [aluIsaPkg::funcWidth-1:0] fn
	);
		logic [irW-1:0] word;
		word = '0;
		word[aluIsaPkg::opcodeLsb +: aluIsaPkg::opcodeWidth] = op;
		word[aluIsaPkg::funcLsb +: aluIsaPkg::funcWidth] = fn;
		return word;
	endfunction

	function automatic logic [width-1:0] randValue();
		logic [width-1:0] v;
		v = '0;
		for (int k = 0; k < width; k += 32)
			v = (v << 32) | width'($urandom());
		return v;
	endfunction

	// Walks down from the top bit until the first one
	function automatic logic [width-1:0] leadZeros(input logic [width-1:0] v);
		int n;
		n = 0;
		while (n < width && !v[width-1-n])
			n++;
		return width'(n);
	endfunction

	function automatic logic [width-1:0] compareFlags(
		input logic [width-1:0] a,
		input logic [width-1:0] b
	);
		logic [width-1:0] f;
		f = '0;
		f[aluDataPkg::cmpEq] = (a == b);
		f[aluDataPkg::cmpNe] = (a != b);
		f[aluDataPkg::cmpLt] = ($signed(a) < $signed(b));
		f[aluDataPkg::cmpLe] = ($signed(a) <= $signed(b));
		f[aluDataPkg::cmpLtu] = (a < b);
		f[aluDataPkg::cmpLeu] = (a <= b);
		return f;
	endfunction

	// Returns carryRes in the upper half and result in the lower half
	function automatic logic [2*width-1:0] modelExec(
		input logic [irW-1:0] word,
		input logic [width-1:0] a,
		input logic [width-1:0] b,
		input logic [width-1:0] c,
		input logic [width-1:0] i,
		input logic ci
	);
		logic [aluIsaPkg::opcodeWidth-1:0] op;
		logic [aluIsaPkg::funcWidth-1:0] fn;
		logic [width-1:0] r;
		logic [width-1:0] cr;
		logic [width-1:0] sl;
		logic [width-1:0] slOut;
		logic [width-1:0] sr;
		logic [width-1:0] srOut;
		logic [width-1:0] sa;
		int s;
		op = word[aluIsaPkg::opcodeLsb +: aluIsaPkg::opcodeWidth];
		fn = word[aluIsaPkg::funcLsb +: aluIsaPkg::funcWidth];
		r = '0;
		cr = '0;
		// Shift amount is its source taken modulo the width
		if (op inside {aluIsaPkg::opSlli, aluIsaPkg::opSrli, aluIsaPkg::opSrai})
			s = int'(i % width);
		else
			s = int'(b % width);
		// Bits leaving the top come back right-aligned, bits leaving the bottom left-aligned
		sl = a << s;
		slOut = a >> (width - s);
		sr = a >> s;
		srOut = a << (width - s);
		sa = $signed(a) >>> s;
		case (op)
			aluIsaPkg::opR1:
				case (fn)
					aluIsaPkg::fnCntlz: r = leadZeros(a);
					aluIsaPkg::fnCntlo: r = leadZeros(~a);
					aluIsaPkg::fnNot: r = width'(a == '0);
					default: r = '0;
				endcase
			aluIsaPkg::opR2:
				case (fn)
					aluIsaPkg::fnAdd: {cr[0], r} = {1'b0, a} + {1'b0, b} + (width+1)'(ci);
					aluIsaPkg::fnSub: {cr[0], r} = {1'b0, a} - {1'b0, b} - (width+1)'(ci);
					aluIsaPkg::fnAnd: r = a & b & c;
					aluIsaPkg::fnOr: r = a | b | c;
					aluIsaPkg::fnXor: r = a ^ b ^ c;
					aluIsaPkg::fnCmp: r = compareFlags(a, b);
					aluIsaPkg::fnSll: {cr, r} = {slOut, sl};
					aluIsaPkg::fnSrl: {cr, r} = {srOut, sr};
					aluIsaPkg::fnSra: {cr, r} = {srOut, sa};
					aluIsaPkg::fnRol: r = sl | slOut;
					aluIsaPkg::fnRor: r = sr | srOut;
					// Where a is set the difference mask turns c into b
					aluIsaPkg::fnMux: r = c ^ ((b ^ c) & a);
					aluIsaPkg::fnSlt: r = ($signed(a) < $signed(b)) ? c : '0;
					aluIsaPkg::fnSltu: r = (a < b) ? c : '0;
					aluIsaPkg::fnSeq: r = (a == b) ? c : '0;
					aluIsaPkg::fnSne: r = (a != b) ? c : '0;
					default: r = '0;
				endcase
			aluIsaPkg::opAddi: {cr[0], r} = {1'b0, a} + {1'b0, i} + (width+1)'(ci);
			// Reverse subtract, the immediate is the minuend
			aluIsaPkg::opSubfi: {cr[0], r} = {1'b0, i} - {1'b0, a} - (width+1)'(ci);
			aluIsaPkg::opAndi: r = a & i;
			aluIsaPkg::opOri: r = a | i;
			aluIsaPkg::opXori: r = a ^ i;
			aluIsaPkg::opCmpi: r = compareFlags(a, i);
			aluIsaPkg::opSlti: r = width'($signed(a) < $signed(i));
			aluIsaPkg::opSltui: r = width'(a < i);
			aluIsaPkg::opSeqi: r = width'(a == i);
			aluIsaPkg::opSlli: {cr, r} = {slOut, sl};
			aluIsaPkg::opSrli: {cr, r} = {srOut, sr};
			aluIsaPkg::opSrai: {cr, r} = {srOut, sa};
			default: r = '0;
		endcase
		return {cr, r};
	endfunction

	// ======================================================================
	// Drive and check helpers
	// ======================================================================

	task automatic driveInputs(
		input logic [irW-1:0] word,
		input logic [width-1:0] a,
		input logic [width-1:0] b,
		input logic [width-1:0] c,
		input logic [width-1:0] i,
		input logic ci
	);
		issue = 1'b1;
		ir = word;
		xa = a;
		xb = b;
		xc = c;
		imm = i;
		carryIn = ci;
	endtask

	task automatic checkOutputs(input logic [2*width-1:0] expected, input string label);
		checks++;
		assert (result === expected[width-1:0]) else
		begin
			errors++;
			$display("Fail at %0t: %s result %h, expected %h", $time, label, result,
				expected[width-1:0]);
		end
		checks++;
		assert (carryRes === expected[2*width-1:width]) else
		begin
			errors++;
			$display("Fail at %0t: %s carry %h, expected %h", $time, label, carryRes,
				expected[2*width-1:width]);
		end
	endtask

	// Issues one instruction alone and checks it in its done cycle and in the idle cycle after
	task automatic runOne(
		input logic [irW-1:0] word,
		input logic [width-1:0] a,
		input logic [width-1:0] b,
		input logic [width-1:0] c,
		input logic [width-1:0] i,
		input logic ci,
		input string label
	);
		logic [2*width-1:0] expected;
		int waited;
		expected = modelExec(word, a, b, c, i, ci);
		waited = 0;
		@(posedge clk);
		#1;
		driveInputs(word, a, b, c, i, ci);
		@(posedge clk);
		#1;
		// Other operands on the idle cycle that follows must not reach the outputs
		driveInputs(~word, ~a, ~b, ~c, ~i, ~ci);
		issue = 1'b0;
		// done should be up already, a late one gets a few cycles
		while (done !== 1'b1 && waited < 4)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		checks++;
		assert (done === 1'b1) else
		begin
			errors++;
			$display("Error at %0t: done never rose after issuing %s", $time, label);
		end
		checkOutputs(expected, label);
		// The output registers keep their value while done is low
		@(posedge clk);
		#1;
		checkOutputs(expected, $sformatf("%s held", label));
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	// Entered at the end of the reset window, releases reset itself
	task automatic resetState();
		checks++;
		assert (done === 1'b0 && result === '0 && carryRes === '0) else
		begin
			errors++;
			$display("Fail at %0t: outputs not cleared by reset", $time);
		end
		rstN = 1'b1;
		repeat (4)
		begin
			@(posedge clk);
			#1;
			checks++;
			assert (done === 1'b0) else
			begin
				errors++;
				$display("Fail at %0t: done rose with no issue", $time);
			end
		end
	endtask

	task automatic arithOps();
		logic [irW-1:0] words [4];
		logic [width-1:0] a;
		logic [width-1:0] b;
		words = '{
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnAdd),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnSub),
			makeIr(aluIsaPkg::opAddi, '0),
			makeIr(aluIsaPkg::opSubfi, '0)
		};
		for (int op = 0; op < 4; op++)
			for (int ci = 0; ci < 2; ci++)
				for (int k = 0; k < 5; k++)
				begin
					// Edge cases first: all ones, largest positive, zero against all ones
					a = (k == 0) ? '1 : (k == 1) ? {1'b0, {(width-1){1'b1}}} : (k == 2) ? '0
						: randValue();
					b = (k < 2) ? width'(1) : (k == 2) ? '1 : randValue();
					// Whichever of xb and imm the op ignores carries the complement
					runOne(words[op], a, (op < 2) ? b : ~b, randValue(),
						(op < 2) ? ~b : b, ci[0],
						$sformatf("arith op %0d carry %0d case %0d", op, ci, k));
				end
	endtask

	task automatic logicOps();
		logic [irW-1:0] words [8];
		logic [irW-1:0] undef [3];
		words = '{
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnAnd),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnOr),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnXor),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnMux),
			makeIr(aluIsaPkg::opAndi, '0),
			makeIr(aluIsaPkg::opOri, '0),
			makeIr(aluIsaPkg::opXori, '0),
			makeIr(aluIsaPkg::opR1, aluIsaPkg::fnNot)
		};
		for (int op = 0; op < 8; op++)
			for (int k = 0; k < 3; k++)
				runOne(words[op], randValue(), randValue(), randValue(), randValue(), 1'b0,
					$sformatf("logic op %0d case %0d", op, k));
		runOne(words[7], '0, randValue(), randValue(), randValue(), 1'b0, "NOT of zero");
		// Codes outside the encoding give zero result and zero carry
		undef = '{
			makeIr(7'h7F, '0),
			makeIr(aluIsaPkg::opR2, 7'h7F),
			makeIr(aluIsaPkg::opR1, 7'h7F)
		};
		for (int k = 0; k < 3; k++)
			runOne(undef[k], randValue(), randValue(), randValue(), randValue(), 1'b1,
				$sformatf("undefined code %0d", k));
	endtask

	task automatic compareOps();
		logic [irW-1:0] words [9];
		logic [width-1:0] pa [4];
		logic [width-1:0] pb [4];
		logic [width-1:0] same;
		words = '{
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnCmp),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnSlt),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnSltu),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnSeq),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnSne),
			makeIr(aluIsaPkg::opCmpi, '0),
			makeIr(aluIsaPkg::opSlti, '0),
			makeIr(aluIsaPkg::opSltui, '0),
			makeIr(aluIsaPkg::opSeqi, '0)
		};
		same = randValue();
		// Equal, negative against positive, small against unsigned-large, sign boundary
		pa = '{same, -width'(5), width'(3), {1'b1, {(width-1){1'b0}}}};
		pb = '{same, width'(3), '1, {1'b0, {(width-1){1'b1}}}};
		// Register forms see the complement in imm and immediate forms see it in xb
		for (int op = 0; op < 9; op++)
			for (int k = 0; k < 4; k++)
				runOne(words[op], pa[k], (op < 5) ? pb[k] : ~pb[k],
					randValue() | width'(1), (op < 5) ? ~pb[k] : pb[k], 1'b0,
					$sformatf("compare op %0d pair %0d", op, k));
	endtask

	task automatic shiftOps();
		logic [irW-1:0] words [8];
		int amounts [4];
		logic [width-1:0] a;
		logic [width-1:0] src;
		words = '{
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnSll),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnSrl),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnSra),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnRol),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnRor),
			makeIr(aluIsaPkg::opSlli, '0),
			makeIr(aluIsaPkg::opSrli, '0),
			makeIr(aluIsaPkg::opSrai, '0)
		};
		for (int op = 0; op < 8; op++)
		begin
			amounts = '{0, 1, int'($urandom_range(2, width - 2)), width - 1};
			for (int k = 0; k < 4; k++)
			begin
				a = randValue();
				// Odd slots set the sign bit so SRA fills with ones
				a[width-1] = k[0];
				// Bits above the amount field are junk (width is a power of two)
				src = (randValue() & ~width'(width - 1)) | width'(amounts[k]);
				// The unused amount source gets the complement, whose low bits differ
				runOne(words[op], a, (op < 5) ? src : ~src, randValue(),
					(op < 5) ? ~src : src, 1'b0,
					$sformatf("shift op %0d amount %0d", op, amounts[k]));
			end
		end
	endtask

	// Counts and adds issued every cycle, each done cycle checked in order
	task automatic countBackToBack();
		logic [width-1:0] vals [6];
		logic [irW-1:0] words [3];
		logic [2*width-1:0] pending [$];
		logic [width-1:0] a;
		logic [width-1:0] b;
		vals = '{'0, '1, width'(1), {1'b1, {(width-1){1'b0}}}, width'(1) << 20,
			~(width'(1) << 37)};
		words = '{
			makeIr(aluIsaPkg::opR1, aluIsaPkg::fnCntlz),
			makeIr(aluIsaPkg::opR1, aluIsaPkg::fnCntlo),
			makeIr(aluIsaPkg::opR2, aluIsaPkg::fnAdd)
		};
		for (int k = 0; k <= 18; k++)
		begin
			@(posedge clk);
			#1;
			if (k > 0)
			begin
				checks++;
				assert (done === 1'b1) else
				begin
					errors++;
					$display("Fail at %0t: done low in back-to-back slot %0d", $time, k - 1);
				end
				checkOutputs(pending.pop_front(), $sformatf("back-to-back slot %0d", k - 1));
			end
			if (k < 18)
			begin
				// The op index shifts per block so every value meets every op
				a = vals[k % 6];
				b = randValue();
				driveInputs(words[(k + k / 6) % 3], a, b, '0, b, k[0]);
				pending.push_back(modelExec(words[(k + k / 6) % 3], a, b, '0, b, k[0]));
			end
			else
				issue = 1'b0;
		end
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial
	begin
		void'($urandom(32'hcf82_fa99));
		issue = 1'b0;
		ir = '0;
		xa = '0;
		xb = '0;
		xc = '0;
		imm = '0;
		carryIn = 1'b0;
		// A clean falling edge so the asynchronous reset fires
		rstN = 1'b1;
		#1;
		rstN = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		resetState();
		arithOps();
		logicOps();
		compareOps();
		shiftOps();
		countBackToBack();
		$display("Closing: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/aluExec_assert.sv ====
/* Timing checks bound into every aluExecStage instance. The reset check expects
   a clean falling edge on rstN before the first rising clock edge */
`timescale 1ns/100ps
`default_nettype none

module aluExecAssert #(
	parameter int valueWidth = aluDataPkg::defaultValueWidth
) (
	input logic clk,
	input logic rstN,
	input logic issue,
	input logic done,
	input logic [valueWidth-1:0] result
);

	// done is the issue strobe delayed by exactly one cycle
	doneFollowsIssue: assert property (@(posedge clk) disable iff (!rstN) done == $past(issue))
		else $error("done does not follow issue by one cycle");

	// Reset holds the stage idle
	doneLowInReset: assert property (@(posedge clk) !rstN |-> !done)
		else $error("done is high while reset is asserted");

	// A result handed to the consumer must be fully defined
	resultKnown: assert property (@(posedge clk) disable iff (!rstN) done |-> !$isunknown(result))
		else $error("result has unknown bits in a done cycle");

endmodule

bind aluExecStage aluExecAssert #(.valueWidth(valueWidth)) timingChecks (
	.clk(clk),
	.rstN(rstN),
	.issue(issue),
	.done(done),
	.result(result)
);

`default_nettype wire

// ==== logic/aluExecStage.sv ====
/* One-cycle execute stage, one issue per cycle and no back-pressure. The
   consumer must take result and carryRes in the cycle that done is high */
`timescale 1ns/100ps
`default_nettype none

module aluExecStage #(
	parameter int valueWidth = aluDataPkg::defaultValueWidth
) (
	input logic clk,
	input logic rstN,
	input logic issue,
	input logic [aluIsaPkg::instrWidth-1:0] ir,
	input logic [valueWidth-1:0] xa,
	input logic [valueWidth-1:0] xb,
	input logic [valueWidth-1:0] xc,
	input logic [valueWidth-1:0] imm,
	input logic carryIn,
	output logic done,
	output logic [valueWidth-1:0] result,
	output logic [valueWidth-1:0] carryRes
);

	logic [valueWidth-1:0] coreResult;
	logic [valueWidth-1:0] coreCarry;

	// The whole datapath settles within the issue cycle
	aluCore #(.valueWidth(valueWidth)) core (
		.ir(ir),
		.xa(xa),
		.xb(xb),
		.xc(xc),
		.imm(imm),
		.carryIn(carryIn),
		.result(coreResult),
		.carryRes(coreCarry)
	);

	// ======================================================================
	// Output register
	// ======================================================================

	// done follows issue by one cycle
	// The value registers load only on issue, so they hold while done is low
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			done <= 1'b0;
			result <= '0;
			carryRes <= '0;
		end
		else
		begin
			done <= issue;
			if (issue)
			begin
				result <= coreResult;
				carryRes <= coreCarry;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/aluCore.sv ====
/* Combinational execute datapath. Undefined opcodes and functions give zero
   result and carry; shifts use the low log2(valueWidth) bits of xb or imm */
`timescale 1ns/100ps
`default_nettype none

module aluCore #(
	parameter int valueWidth = aluDataPkg::defaultValueWidth
) (
	input logic [aluIsaPkg::instrWidth-1:0] ir,
	input logic [valueWidth-1:0] xa,
	input logic [valueWidth-1:0] xb,
	input logic [valueWidth-1:0] xc,
	input logic [valueWidth-1:0] imm,
	input logic carryIn,
	output logic [valueWidth-1:0] result,
	output logic [valueWidth-1:0] carryRes
);

	localparam int amtWidth = aluDataPkg::shiftAmountWidth(valueWidth);
	localparam int countWidth = amtWidth + 1;
	// Arithmetic runs one bit wider, the extra bit is the carry or borrow
	localparam int wideWidth = valueWidth + 1;

	// ======================================================================
	// Decode
	// ======================================================================

	logic [aluIsaPkg::opcodeWidth-1:0] opcode;
	logic [aluIsaPkg::funcWidth-1:0] func;
	logic isImmShift;
	logic isArith;

	assign opcode = ir[aluIsaPkg::opcodeLsb +: aluIsaPkg::opcodeWidth];
	assign func = ir[aluIsaPkg::funcLsb +: aluIsaPkg::funcWidth];

	// Immediate shifts take their amount from imm, R2 shifts from xb
	assign isImmShift = (opcode == aluIsaPkg::opSlli) || (opcode == aluIsaPkg::opSrli)
		|| (opcode == aluIsaPkg::opSrai);
	// Only the two arithmetic right shifts bring in the sign bit
	assign isArith = (opcode == aluIsaPkg::opSrai)
		|| ((opcode == aluIsaPkg::opR2) && (func == aluIsaPkg::fnSra));

	// ======================================================================
	// Sub-units
	// ======================================================================

	logic [aluDataPkg::cmpFlagCount-1:0] cmpRegFlags;
	logic [aluDataPkg::cmpFlagCount-1:0] cmpImmFlags;
	logic [valueWidth-1:0] clzIn;
	logic [countWidth-1:0] clzCount;
	logic [amtWidth-1:0] shfAmount;
	logic shfFill;
	logic [2*valueWidth-1:0] shfLeft;
	logic [2*valueWidth-1:0] shfRight;

	aluCompare #(.valueWidth(valueWidth)) cmpReg (.a(xa), .b(xb), .flags(cmpRegFlags));

	aluCompare #(.valueWidth(valueWidth)) cmpImm (.a(xa), .b(imm), .flags(cmpImmFlags));

	// Leading ones are counted as leading zeros of the inverted operand
	assign clzIn = ((opcode == aluIsaPkg::opR1) && (func == aluIsaPkg::fnCntlo)) ? ~xa : xa;

	aluCountLead #(.valueWidth(valueWidth)) clz (.value(clzIn), .count(clzCount));

	assign shfAmount = isImmShift ? imm[amtWidth-1:0] : xb[amtWidth-1:0];
	assign shfFill = isArith & xa[valueWidth-1];

	aluShifter #(.valueWidth(valueWidth)) shf (
		.value(xa),
		.amount(shfAmount),
		.fill(shfFill),
		.leftOut(shfLeft),
		.rightOut(shfRight)
	);

	// ======================================================================
	// Arithmetic and bitwise select
	// ======================================================================

	logic [valueWidth-1:0] addB;
	logic [valueWidth-1:0] subA;
	logic [valueWidth-1:0] subB;
	logic [wideWidth-1:0] addWide;
	logic [wideWidth-1:0] subWide;
	logic [valueWidth-1:0] muxOut;

	// ADDI swaps imm in for xb
	assign addB = (opcode == aluIsaPkg::opAddi) ? imm : xb;
	assign addWide = {1'b0, xa} + {1'b0, addB} + wideWidth'(carryIn);

	// SUBFI is reversed, imm minus xa
	assign subA = (opcode == aluIsaPkg::opSubfi) ? imm : xa;
	assign subB = (opcode == aluIsaPkg::opSubfi) ? xa : xb;
	assign subWide = {1'b0, subA} - {1'b0, subB} - wideWidth'(carryIn);

	// Each bit from xb where xa is set, else from xc
	assign muxOut = (xa & xb) | (~xa & xc);

	// ======================================================================
	// Result and carry selection
	// ======================================================================

	always_comb
	begin
		result = '0;
		carryRes = '0;
		case (opcode)
			aluIsaPkg::opR1:
				case (func)
					aluIsaPkg::fnCntlz, aluIsaPkg::fnCntlo: result = valueWidth'(clzCount);
					aluIsaPkg::fnNot: result = valueWidth'(xa == '0);
					default: result = '0;
				endcase
			aluIsaPkg::opR2:
				case (func)
					aluIsaPkg::fnAdd:
					begin
						result = addWide[valueWidth-1:0];
						carryRes = valueWidth'(addWide[valueWidth]);
					end
					aluIsaPkg::fnSub:
					begin
						result = subWide[valueWidth-1:0];
						carryRes = valueWidth'(subWide[valueWidth]);
					end
					aluIsaPkg::fnAnd: result = xa & xb & xc;
					aluIsaPkg::fnOr: result = xa | xb | xc;
					aluIsaPkg::fnXor: result = xa ^ xb ^ xc;
					aluIsaPkg::fnCmp: result = valueWidth'(cmpRegFlags);
					aluIsaPkg::fnSll:
					begin
						result = shfLeft[valueWidth-1:0];
						carryRes = shfLeft[2*valueWidth-1:valueWidth];
					end
					aluIsaPkg::fnSrl, aluIsaPkg::fnSra:
					begin
						result = shfRight[2*valueWidth-1:valueWidth];
						carryRes = shfRight[valueWidth-1:0];
					end
					// Rotates fold the shifted-out bits back in and keep no carry
					aluIsaPkg::fnRol:
						result = shfLeft[valueWidth-1:0] | shfLeft[2*valueWidth-1:valueWidth];
					aluIsaPkg::fnRor:
						result = shfRight[2*valueWidth-1:valueWidth] | shfRight[valueWidth-1:0];
					aluIsaPkg::fnMux: result = muxOut;
					aluIsaPkg::fnSlt: result = cmpRegFlags[aluDataPkg::cmpLt] ? xc : '0;
					aluIsaPkg::fnSltu: result = cmpRegFlags[aluDataPkg::cmpLtu] ? xc : '0;
					aluIsaPkg::fnSeq: result = cmpRegFlags[aluDataPkg::cmpEq] ? xc : '0;
					aluIsaPkg::fnSne: result = cmpRegFlags[aluDataPkg::cmpNe] ? xc : '0;
					default: result = '0;
				endcase
			aluIsaPkg::opAddi:
			begin
				result = addWide[valueWidth-1:0];
				carryRes = valueWidth'(addWide[valueWidth]);
			end
			aluIsaPkg::opSubfi:
			begin
				result = subWide[valueWidth-1:0];
				carryRes = valueWidth'(subWide[valueWidth]);
			end
			aluIsaPkg::opAndi: result = xa & imm;
			aluIsaPkg::opOri: result = xa | imm;
			aluIsaPkg::opXori: result = xa ^ imm;
			aluIsaPkg::opCmpi: result = valueWidth'(cmpImmFlags);
			// Immediate set-if forms give a plain one or zero
			aluIsaPkg::opSlti: result = valueWidth'(cmpImmFlags[aluDataPkg::cmpLt]);
			aluIsaPkg::opSltui: result = valueWidth'(cmpImmFlags[aluDataPkg::cmpLtu]);
			aluIsaPkg::opSeqi: result = valueWidth'(cmpImmFlags[aluDataPkg::cmpEq]);
			aluIsaPkg::opSlli:
			begin
				result = shfLeft[valueWidth-1:0];
				carryRes = shfLeft[2*valueWidth-1:valueWidth];
			end
			aluIsaPkg::opSrli, aluIsaPkg::opSrai:
			begin
				result = shfRight[2*valueWidth-1:valueWidth];
				carryRes = shfRight[valueWidth-1:0];
			end
			default:
			begin
				result = '0;
				carryRes = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/aluShifter.sv ====
/* Double-width barrel shifter, combinational. Amounts reach valueWidth-1 only,
   so a full-width shift is not expressible */
`timescale 1ns/100ps
`default_nettype none

module aluShifter #(
	parameter int valueWidth = aluDataPkg::defaultValueWidth
) (
	input logic [valueWidth-1:0] value,
	input logic [aluDataPkg::shiftAmountWidth(valueWidth)-1:0] amount,
	input logic fill,
	output logic [2*valueWidth-1:0] leftOut,
	output logic [2*valueWidth-1:0] rightOut
);

	// ======================================================================
	// Left shift
	// ======================================================================

	logic [2*valueWidth-1:0] leftIn;

	// The value starts in the low half with zeros above it
	assign leftIn = {{valueWidth{1'b0}}, value};

	// Low half is the shift result
	// High half holds the bits pushed out of the top, right-aligned
	assign leftOut = leftIn << amount;

	// ======================================================================
	// Right shift
	// ======================================================================

	// Three value widths wide so the fill bits above the value are not lost
	// before they get shifted down into the upper half
	logic [3*valueWidth-1:0] rightIn;
	logic [3*valueWidth-1:0] rightWide;

	// Fill is the sign bit for an arithmetic shift and zero otherwise
	assign rightIn = {{valueWidth{fill}}, value, {valueWidth{1'b0}}};

	assign rightWide = rightIn >> amount;

	// Upper half is the shift result
	// Lower half holds the bits pushed out of the bottom, left-aligned
	// The top third only ever carries fill and is dropped here
	assign rightOut = rightWide[2*valueWidth-1:0];

	// A rotate is the OR of both halves of either output, the core does that

endmodule

`default_nettype wire

// ==== logic/aluCountLead.sv ====
/* Leading-zero counter. Count leading ones by feeding the inverted value, an
   all-zero input counts as valueWidth */
`timescale 1ns/100ps
`default_nettype none

module aluCountLead #(
	parameter int valueWidth = aluDataPkg::defaultValueWidth
) (
	input logic [valueWidth-1:0] value,
	output logic [aluDataPkg::shiftAmountWidth(valueWidth):0] count
);

	// One bit more than a shift amount so that valueWidth itself fits
	localparam int countWidth = aluDataPkg::shiftAmountWidth(valueWidth) + 1;

	// Priority scan, the highest set bit is the last one to win
	always_comb
	begin
		count = countWidth'(valueWidth);
		for (int i = 0; i < valueWidth; i++)
		begin
			if (value[i])
			begin
				count = countWidth'(valueWidth - 1 - i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/aluCompare.sv ====
/* Magnitude comparator, combinational. Flags sit at the aluDataPkg positions */
`timescale 1ns/100ps
`default_nettype none

module aluCompare #(
	parameter int valueWidth = aluDataPkg::defaultValueWidth
) (
	input logic [valueWidth-1:0] a,
	input logic [valueWidth-1:0] b,
	output logic [aluDataPkg::cmpFlagCount-1:0] flags
);

	logic isEq;
	logic isLt;
	logic isLtu;

	// One equality and two less-than compares cover all six flags
	assign isEq = (a == b);
	assign isLt = ($signed(a) < $signed(b));
	assign isLtu = (a < b);

	always_comb
	begin
		flags = '0;
		flags[aluDataPkg::cmpEq] = isEq;
		flags[aluDataPkg::cmpNe] = ~isEq;
		flags[aluDataPkg::cmpLt] = isLt;
		// Less-or-equal is less-than widened by equality
		flags[aluDataPkg::cmpLe] = isLt | isEq;
		flags[aluDataPkg::cmpLtu] = isLtu;
		flags[aluDataPkg::cmpLeu] = isLtu | isEq;
	end

endmodule

`default_nettype wire

// ==== logic/aluDataPkg.sv ====
/* Data-path constants. The value width here is only a default, the top level
   parameter decides the real width */
`default_nettype none

package aluDataPkg;

	localparam int defaultValueWidth = 64;

	// Compare flag vector, Lt and Le are signed, Ltu and Leu unsigned
	localparam int cmpFlagCount = 6;
	localparam int cmpEq = 0;
	localparam int cmpNe = 1;
	localparam int cmpLt = 2;
	localparam int cmpLe = 3;
	localparam int cmpLtu = 4;
	localparam int cmpLeu = 5;

	// Bits of shift amount needed to reach every position of a value
	function automatic int shiftAmountWidth(input int width);
		return $clog2(width);
	endfunction

endpackage

`default_nettype wire

// ==== logic/aluIsaPkg.sv ====
/* Instruction encoding of the execute stage. R1 and R2 share the function field
   in bits 31 to 25, and every opcode and function code is 7 bits wide */
`default_nettype none

package aluIsaPkg;

	// Field positions inside the 32-bit instruction word
	localparam int instrWidth = 32;
	localparam int opcodeLsb = 0;
	localparam int opcodeWidth = 7;
	localparam int funcLsb = 25;
	localparam int funcWidth = 7;

	// ======================================================================
	// Major opcodes
	// ======================================================================

	// Register groups, the operation is picked by the function field
	localparam logic [opcodeWidth-1:0] opR1 = 7'h01;
	localparam logic [opcodeWidth-1:0] opR2 = 7'h02;

	// Immediate forms take imm in place of xb
	localparam logic [opcodeWidth-1:0] opAddi = 7'h04;
	localparam logic [opcodeWidth-1:0] opSubfi = 7'h05;
	localparam logic [opcodeWidth-1:0] opAndi = 7'h08;
	localparam logic [opcodeWidth-1:0] opOri = 7'h09;
	localparam logic [opcodeWidth-1:0] opXori = 7'h0A;
	localparam logic [opcodeWidth-1:0] opCmpi = 7'h0B;
	localparam logic [opcodeWidth-1:0] opSlti = 7'h0C;
	localparam logic [opcodeWidth-1:0] opSltui = 7'h0D;
	localparam logic [opcodeWidth-1:0] opSeqi = 7'h0E;
	localparam logic [opcodeWidth-1:0] opSlli = 7'h10;
	localparam logic [opcodeWidth-1:0] opSrli = 7'h11;
	localparam logic [opcodeWidth-1:0] opSrai = 7'h12;

	// R1 functions, single operand in xa
	// CNTLO differs from CNTLZ only in bit 0
	localparam logic [funcWidth-1:0] fnCntlz = 7'h00;
	localparam logic [funcWidth-1:0] fnCntlo = 7'h01;
	localparam logic [funcWidth-1:0] fnNot = 7'h02;

	// R2 functions
	localparam logic [funcWidth-1:0] fnAdd = 7'h04;
	localparam logic [funcWidth-1:0] fnSub = 7'h05;
	localparam logic [funcWidth-1:0] fnAnd = 7'h08;
	localparam logic [funcWidth-1:0] fnOr = 7'h09;
	localparam logic [funcWidth-1:0] fnXor = 7'h0A;
	localparam logic [funcWidth-1:0] fnCmp = 7'h0B;
	localparam logic [funcWidth-1:0] fnSll = 7'h10;
	localparam logic [funcWidth-1:0] fnSrl = 7'h11;
	localparam logic [funcWidth-1:0] fnSra = 7'h12;
	localparam logic [funcWidth-1:0] fnRol = 7'h13;
	localparam logic [funcWidth-1:0] fnRor = 7'h14;
	localparam logic [funcWidth-1:0] fnMux = 7'h18;
	localparam logic [funcWidth-1:0] fnSlt = 7'h20;
	localparam logic [funcWidth-1:0] fnSltu = 7'h21;
	localparam logic [funcWidth-1:0] fnSeq = 7'h22;
	localparam logic [funcWidth-1:0] fnSne = 7'h23;

endpackage

`default_nettype wire
